// ==== vlog.f ====
logic/cfi_pkg.sv
logic/commit_classifier.sv
logic/landing_pad_checker.sv
logic/return_addr_stack.sv
logic/shadow_stack_checker.sv
logic/cfi_violation_reporter.sv
logic/cfi_monitor.sv
tests/cfi_monitor_properties.sv
tests/cfi_monitor_tb.sv

// ==== Bender.yml ====
package:
  name: cfi_monitor

sources:
  - logic/cfi_pkg.sv
  - logic/commit_classifier.sv
  - logic/landing_pad_checker.sv
  - logic/return_addr_stack.sv
  - logic/shadow_stack_checker.sv
  - logic/cfi_violation_reporter.sv
  - logic/cfi_monitor.sv
  - target: test
    files:
      - tests/cfi_monitor_properties.sv
      - tests/cfi_monitor_tb.sv

// ==== tests/cfi_monitor_tb.sv ====
// testbench for the CFI monitor with a stack depth of 4; never expects a second return check in one cycle
`timescale 1ns/10ps

module cfi_monitor_tb;

   localparam int unsigned DEPTH = 4;
   localparam int unsigned LIMIT = 2000;

   logic clk_i, rst_ni, csr_en_i, cfi_halt_o, args_clear_o;
   logic [1:0] commit_ack_i;
   logic [8:0] csr_nargs_i;
   cfi_pkg::commit_entry_t [1:0] commit_instr_i;
   cfi_pkg::exception_t exception_o;

   // reference model state
   cfi_pkg::commit_entry_t ent [2];
   logic [31:0] ras [$];
   logic pad_wait, ret_wait, en_r, exp_v, exp_clr;
   logic [8:0] nargs_r;
   logic [31:0] exp_tval, rnd_state, a, t;
   int unsigned cycles;

   cfi_monitor #(.STACK_DEPTH(DEPTH), .HALT_CYCLES(4)) i_cfi_monitor (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("run did not finish within %0d cycles", LIMIT);
         $display("Testbench failed");
         $fatal(1);
      end else if (i_cfi_monitor.i_cfi_monitor_properties.fail_count != 0) begin
         $display("a bound timing assertion failed at %0t", $time);
         $display("Testbench failed");
         $fatal(1);
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] rand_word();
      rnd_state = xorshift(rnd_state);
      return rnd_state;
   endfunction

   function automatic cfi_pkg::commit_entry_t mk(input logic [31:0] pc, input cfi_pkg::fu_op_e op,
                                                 input logic [4:0] rd, rs1, input logic [31:0] imm);
      cfi_pkg::commit_entry_t e;
      e.pc       = {pc[31:2], 2'b00};
      e.op       = op;
      e.rd       = rd;
      e.rs1      = rs1;
      e.result   = imm;
      e.ex_valid = 1'b0;
      return e;
   endfunction

   // a pad is addi x0, x0 with the count in 10:2, the variadic flag in 11 and mark 2 below
   function automatic cfi_pkg::commit_entry_t pad(input logic [31:0] pc, input logic [8:0] n,
                                                  input logic v);
      return mk(pc, cfi_pkg::OP_ADD, 5'd0, 5'd0, {20'd0, v, n, 2'b10});
   endfunction

   function automatic logic pad_ok(input cfi_pkg::commit_entry_t e);
      logic args;
      args = (nargs_r == 9'h1ff) || (e.result[11] ? e.result[10:2] >= nargs_r
                                                  : e.result[10:2] == nargs_r);
      return e.op == cfi_pkg::OP_ADD && e.rd == 0 && e.rs1 == 0 && e.result[1:0] == 2 && args;
   endfunction

   task automatic bad_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1);
   endtask

   // one commit cycle, checking the outputs that belong to the previous one
   task automatic step(input logic [1:0] ack);
      logic pv, rv, ov, calls, clr, call, ret, lnk_rd, lnk_rs;
      logic [31:0] pt, rt, ot;
      @(posedge clk_i);
      commit_ack_i      <= ack;
      commit_instr_i[0] <= ent[0];
      commit_instr_i[1] <= ent[1];
      csr_en_i          <= en_r;
      csr_nargs_i       <= nargs_r;
      {pv, rv, ov, calls, pt, rt, ot} = '0;
      clr = !en_r;
      for (int i = 0; i < 2; i++) begin
         if (ack[i] && !ent[i].ex_valid) begin
            lnk_rd = ent[i].rd == 1 || ent[i].rd == 5;
            lnk_rs = ent[i].rs1 == 1 || ent[i].rs1 == 5;
            call   = lnk_rd && (ent[i].op == cfi_pkg::OP_JAL || ent[i].op == cfi_pkg::OP_JALR);
            ret    = ent[i].op == cfi_pkg::OP_JALR && ent[i].rd == 0 && lnk_rs;
            if (pad_wait) begin
               clr = 1'b1;
               if (!pad_ok(ent[i]) && !pv) {pv, pt} = {1'b1, ent[i].pc};
            end
            if (ret_wait) begin
               if (ras.size() > 0 && ras[$] == ent[i].pc) void'(ras.pop_back());
               else if (!rv) {rv, rt} = {1'b1, ent[i].pc};
            end
            if (call) begin
               if (calls || ras.size() == DEPTH) {ov, ot} = {1'b1, ent[i].pc};
               else ras.push_back(ent[i].pc + 4);
               calls = 1'b1;
            end
            pad_wait = call;
            ret_wait = ret;
         end
      end
      @(negedge clk_i);
      assert (exception_o.valid == exp_v)
         else bad_value("exception_o.valid", exception_o.valid, exp_v);
      if (exp_v) begin
         assert (exception_o.tval == exp_tval)
            else bad_value("exception_o.tval", exception_o.tval, exp_tval);
      end
      assert (args_clear_o == exp_clr)
         else bad_value("args_clear_o", args_clear_o, exp_clr);
      exp_v    = en_r && (rv || ov || pv);
      exp_tval = rv ? rt : (ov ? ot : pt);
      exp_clr  = clr;
   endtask

   task automatic call_then_ret(input logic [31:0] a, t, input logic [8:0] n, input logic v, split);
      ent[0] = mk(a, cfi_pkg::OP_JAL, 5'd1, 5'd0, 0);
      ent[1] = pad(t, n, v);
      if (split) begin
         step(2'b01);
         step(2'b00);
         ent[0] = pad(t, n, v);
         step(2'b01);
      end else begin
         step(2'b11);
      end
      ent[0] = mk(t + 8, cfi_pkg::OP_JALR, 5'd0, 5'd1, 0);
      ent[1] = mk(a + 4, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      step(2'b11);
      step(2'b00);
   endtask

   initial begin
      {commit_ack_i, commit_instr_i, exp_v, exp_clr, exp_tval, pad_wait, ret_wait} = '0;
      rst_ni = 1'b0;
      csr_en_i = 1'b1;
      en_r = 1'b1;
      csr_nargs_i = 9'd3;
      nargs_r = 9'd3;
      cycles = 0;
      rnd_state = 32'd2;
      ent[0] = '0;
      ent[1] = '0;
      repeat (8) @(posedge clk_i);
      rst_ni <= 1'b1;

      call_then_ret(rand_word(), rand_word(), 3, 0, 0);
      call_then_ret(rand_word(), rand_word(), 3, 0, 1);
      call_then_ret(rand_word(), rand_word(), 2, 0, 0);
      call_then_ret(rand_word(), rand_word(), 2, 1, 1);
      call_then_ret(rand_word(), rand_word(), 5, 1, 0);
      nargs_r = 9'h1ff;
      call_then_ret(rand_word(), rand_word(), 7, 0, 0);
      nargs_r = 9'd3;
      // missing pad, then a linked swap whose return target is checked on port 1
      a = rand_word();
      ent[0] = mk(a, cfi_pkg::OP_JAL, 5'd5, 5'd0, 0);
      ent[1] = mk(a + 4, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      step(2'b11);
      step(2'b00);
      ent[0] = mk(a + 8, cfi_pkg::OP_JALR, 5'd0, 5'd5, 0);
      ent[1] = mk(a + 4, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      step(2'b11);
      ent[0] = mk(a + 32, cfi_pkg::OP_JALR, 5'd1, 5'd5, 0);
      ent[1] = pad(a + 36, 3, 0);
      step(2'b11);
      step(2'b00);
      // a call nested inside the one above, then a wrong return
      t = rand_word();
      call_then_ret(t, t + 64, 3, 0, 0);
      ent[0] = mk(a, cfi_pkg::OP_JALR, 5'd0, 5'd1, 0);
      ent[1] = mk(a + 12, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      step(2'b11);
      step(2'b00);
      // the matching return empties the stack and the next return finds it empty
      ent[0] = mk(a + 40, cfi_pkg::OP_JALR, 5'd0, 5'd1, 0);
      ent[1] = mk(a + 36, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      step(2'b11);
      ent[0] = mk(a + 44, cfi_pkg::OP_JALR, 5'd0, 5'd1, 0);
      ent[1] = mk(a + 48, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      step(2'b11);
      step(2'b00);
      // a return in place of the pad, with a wrong target, reports the return
      ent[0] = mk(a + 48, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      ent[1] = mk(a + 52, cfi_pkg::OP_JAL, 5'd1, 5'd0, 0);
      step(2'b11);
      ent[0] = mk(a + 60, cfi_pkg::OP_JALR, 5'd0, 5'd1, 0);
      ent[1] = mk(a + 200, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      step(2'b11);
      step(2'b00);
      ent[0] = mk(a + 64, cfi_pkg::OP_JALR, 5'd0, 5'd1, 0);
      ent[1] = mk(a + 56, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      step(2'b11);
      // five nested calls against a depth of four, then unwind
      for (int i = 0; i < 5; i++) begin
         ent[0] = mk(a + 256 * i, cfi_pkg::OP_JAL, 5'd1, 5'd0, 0);
         ent[1] = pad(a + 256 * i + 128, 3, 0);
         step(2'b11);
         step(2'b00);
      end
      for (int i = 3; i >= 0; i--) begin
         ent[0] = mk(a + 4000, cfi_pkg::OP_JALR, 5'd0, 5'd1, 0);
         ent[1] = mk(a + 256 * i + 4, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
         step(2'b11);
      end
      // disabled monitor swallows a missing pad and a return to an empty stack
      en_r = 1'b0;
      ent[0] = mk(a, cfi_pkg::OP_JALR, 5'd0, 5'd1, 0);
      ent[1] = mk(a + 8, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      step(2'b11);
      ent[0] = mk(a, cfi_pkg::OP_JAL, 5'd1, 5'd0, 0);
      step(2'b11);
      en_r = 1'b1;
      ent[0] = mk(a + 8, cfi_pkg::OP_JALR, 5'd0, 5'd1, 0);
      ent[1] = mk(a + 4, cfi_pkg::OP_OTHER, 5'd0, 5'd0, 0);
      step(2'b11);
      step(2'b00);
      for (int i = 0; i < 30; i++) begin
         t = rand_word();
         call_then_ret(rand_word(), rand_word(), 9'(t[2:0]), t[3], t[4]);
      end
      step(2'b00);
      step(2'b00);
      if (i_cfi_monitor.i_cfi_monitor_properties.fail_count != 0) begin
         $display("a bound timing assertion failed before the end of the run");
         $display("Testbench failed");
         $fatal(1);
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

// ==== tests/cfi_monitor_properties.sv ====
// timing checks on the exception and halt outputs; assumes consecutive exceptions are never expected
`timescale 1ns/10ps

module cfi_monitor_properties #(
   parameter int unsigned HALT_CYCLES = 4
) (
   input logic                clk_i,
   input logic                rst_ni,
   input cfi_pkg::exception_t exception_o,
   input logic                cfi_halt_o,
   input logic                args_clear_o
);

   // number of failed properties so far
   int unsigned fail_count = 0;

   a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      exception_o.valid |=> !exception_o.valid)
      else begin
         $error("exception_o.valid held for two cycles");
         fail_count++;
      end

   a_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
      exception_o.valid |-> (exception_o.cause == cfi_pkg::CAUSE_ILLEGAL_INSTR))
      else begin
         $error("exception cause is not illegal instruction");
         fail_count++;
      end

   // the halt window covers the exception cycle and the cycles after it
   a_halt_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      exception_o.valid |-> cfi_halt_o [*HALT_CYCLES])
      else begin
         $error("cfi_halt_o dropped early");
         fail_count++;
      end

   a_halt_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
      exception_o.valid ##1 (!exception_o.valid) [*HALT_CYCLES] |-> !cfi_halt_o)
      else begin
         $error("cfi_halt_o held too long");
         fail_count++;
      end

   a_halt_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(cfi_halt_o) |-> exception_o.valid)
      else begin
         $error("cfi_halt_o rose without an exception");
         fail_count++;
      end

   a_reset_quiet: assert property (@(posedge clk_i)
      !rst_ni |=> (!exception_o.valid && !cfi_halt_o && !args_clear_o))
      else begin
         $error("outputs active during reset");
         fail_count++;
      end

endmodule

bind cfi_monitor cfi_monitor_properties #(.HALT_CYCLES(HALT_CYCLES)) i_cfi_monitor_properties (
   .clk_i(clk_i), .rst_ni(rst_ni), .exception_o(exception_o),
   .cfi_halt_o(cfi_halt_o), .args_clear_o(args_clear_o)
);

// ==== logic/cfi_monitor.sv ====
// CFI monitor for a two-port in-order commit stream; commits cannot be stalled and every commit is checked
`timescale 1ns/10ps

module cfi_monitor #(
   parameter int unsigned STACK_DEPTH = 16,
   parameter int unsigned HALT_CYCLES = 4
) (
   input  logic                                                   clk_i,
   input  logic                                                   rst_ni,
   input  logic                                                   csr_en_i,
   input  logic [cfi_pkg::NR_COMMIT_PORTS-1:0]                    commit_ack_i,
   input  cfi_pkg::commit_entry_t [cfi_pkg::NR_COMMIT_PORTS-1:0]  commit_instr_i,
   input  logic [cfi_pkg::NARGS_W-1:0]                            csr_nargs_i,
   output cfi_pkg::exception_t                                    exception_o,
   output logic                                                   cfi_halt_o,
   output logic                                                   args_clear_o
);

   cfi_pkg::commit_class_t [cfi_pkg::NR_COMMIT_PORTS-1:0] cls;
   cfi_pkg::violation_t                                   pad_viol;
   cfi_pkg::violation_t                                   ret_viol;
   cfi_pkg::violation_t                                   ovf_viol;

   commit_classifier i_commit_classifier (
      .clk_i(clk_i), .rst_ni(rst_ni), .commit_ack_i(commit_ack_i),
      .commit_instr_i(commit_instr_i), .csr_nargs_i(csr_nargs_i), .cls_o(cls)
   );

   landing_pad_checker i_landing_pad_checker (
      .clk_i(clk_i), .rst_ni(rst_ni), .csr_en_i(csr_en_i), .cls_i(cls),
      .pad_viol_o(pad_viol), .args_clear_o(args_clear_o)
   );

   shadow_stack_checker #(.STACK_DEPTH(STACK_DEPTH)) i_shadow_stack_checker (
      .clk_i(clk_i), .rst_ni(rst_ni), .cls_i(cls),
      .ret_viol_o(ret_viol), .ovf_viol_o(ovf_viol)
   );

   cfi_violation_reporter #(.HALT_CYCLES(HALT_CYCLES)) i_cfi_violation_reporter (
      .clk_i(clk_i), .rst_ni(rst_ni), .csr_en_i(csr_en_i),
      .pad_viol_i(pad_viol), .ret_viol_i(ret_viol), .ovf_viol_i(ovf_viol),
      .exception_o(exception_o), .cfi_halt_o(cfi_halt_o)
   );

endmodule

// ==== logic/cfi_violation_reporter.sv ====
// registers one violation per cycle into an exception; csr_en_i is sampled in the commit cycle
`timescale 1ns/10ps

module cfi_violation_reporter #(
   parameter int unsigned HALT_CYCLES = 4
) (
   input  logic                clk_i,
   input  logic                rst_ni,
   input  logic                csr_en_i,
   input  cfi_pkg::violation_t pad_viol_i,
   input  cfi_pkg::violation_t ret_viol_i,
   input  cfi_pkg::violation_t ovf_viol_i,
   output cfi_pkg::exception_t exception_o,
   output logic                cfi_halt_o
);

   localparam int unsigned CW = $clog2(HALT_CYCLES + 1);

   cfi_pkg::violation_t      sel;
   logic                     raise;
   logic                     ex_valid_q;
   logic [cfi_pkg::XLEN-1:0] ex_tval_q;
   logic [CW-1:0]            halt_cnt_q;

   ////////////////////////////////////////////////////////////////////////////
   // priority select
   ////////////////////////////////////////////////////////////////////////////

   // return mismatch first, then overflow, then a bad landing pad
   always_comb begin
      if (ret_viol_i.valid) begin
         sel = ret_viol_i;
      end else if (ovf_viol_i.valid) begin
         sel = ovf_viol_i;
      end else begin
         sel = pad_viol_i;
      end
   end

   assign raise = sel.valid && csr_en_i;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         ex_valid_q <= 1'b0;
         halt_cnt_q <= '0;
      end else begin
         ex_valid_q <= raise;
         // every new exception reloads the halt window
         if (raise) begin
            halt_cnt_q <= CW'(HALT_CYCLES);
         end else if (halt_cnt_q != '0) begin
            halt_cnt_q <= halt_cnt_q - CW'(1);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (raise) begin
         ex_tval_q <= sel.tval;
      end
   end

   assign exception_o.valid = ex_valid_q;
   assign exception_o.cause = cfi_pkg::CAUSE_ILLEGAL_INSTR;
   assign exception_o.tval  = ex_tval_q;
   assign cfi_halt_o        = (halt_cnt_q != '0);

endmodule

// ==== logic/shadow_stack_checker.sv ====
// backward edge check; one push and one pop per cycle, a second same-cycle return check fails
`timescale 1ns/10ps

module shadow_stack_checker #(
   parameter int unsigned STACK_DEPTH = 16
) (
   input  logic                                                   clk_i,
   input  logic                                                   rst_ni,
   input  cfi_pkg::commit_class_t [cfi_pkg::NR_COMMIT_PORTS-1:0]  cls_i,
   output cfi_pkg::violation_t                                    ret_viol_o,
   output cfi_pkg::violation_t                                    ovf_viol_o
);

   typedef enum logic {
      IDLE,
      WAIT_TARGET
   } state_e;

   state_e                   state_q, state_d;
   logic                     pushed;
   logic                     popped;
   logic [cfi_pkg::XLEN-1:0] push_addr;
   logic [cfi_pkg::XLEN-1:0] stk_top;
   logic                     stk_empty;
   logic                     stk_full;

   ////////////////////////////////////////////////////////////////////////////
   // check, push and pop decisions
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      logic pending;
      logic call_seen;

      pending    = (state_q == WAIT_TARGET);
      call_seen  = 1'b0;
      pushed     = 1'b0;
      popped     = 1'b0;
      push_addr  = '0;
      ret_viol_o = '0;
      ovf_viol_o = '0;

      for (int i = 0; i < cfi_pkg::NR_COMMIT_PORTS; i++) begin
         if (cls_i[i].valid) begin
            if (pending) begin
               // a cycle pops at most once and a second return check in it fails
               if (!popped && !stk_empty && (cls_i[i].pc == stk_top)) begin
                  popped = 1'b1;
               end else if (!ret_viol_o.valid) begin
                  ret_viol_o.valid = 1'b1;
                  ret_viol_o.tval  = cls_i[i].pc;
               end
            end

            if (cls_i[i].is_call) begin
               // a second call in one cycle has no push slot left
               if (call_seen || (stk_full && !popped)) begin
                  ovf_viol_o.valid = 1'b1;
                  ovf_viol_o.tval  = cls_i[i].pc;
               end else begin
                  pushed    = 1'b1;
                  push_addr = cls_i[i].pc + cfi_pkg::RET_OFFSET;
               end
               call_seen = 1'b1;
            end

            pending = cls_i[i].is_ret;
         end
      end

      state_d = pending ? WAIT_TARGET : IDLE;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   return_addr_stack #(
      .DEPTH(STACK_DEPTH)
   ) i_return_addr_stack (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .push_i     (pushed),
      .push_addr_i(push_addr),
      .pop_i      (popped),
      .top_o      (stk_top),
      .empty_o    (stk_empty),
      .full_o     (stk_full)
   );

endmodule

// ==== logic/return_addr_stack.sv ====
// LIFO of return addresses; DEPTH must be at least 2, push when full and pop when empty are dropped
`timescale 1ns/10ps

module return_addr_stack #(
   parameter int unsigned DEPTH = 16
) (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  logic                     push_i,
   input  logic [cfi_pkg::XLEN-1:0] push_addr_i,
   input  logic                     pop_i,
   output logic [cfi_pkg::XLEN-1:0] top_o,
   output logic                     empty_o,
   output logic                     full_o
);

   localparam int unsigned PW = $clog2(DEPTH + 1);
   localparam int unsigned IW = $clog2(DEPTH);

   logic [cfi_pkg::XLEN-1:0] mem_q [DEPTH];
   logic [PW-1:0]            ptr_q;
   logic [IW-1:0]            top_idx;
   logic                     do_push;
   logic                     do_pop;

   assign empty_o = (ptr_q == '0);
   assign full_o  = (ptr_q == PW'(DEPTH));
   assign top_idx = IW'(ptr_q - PW'(1));
   assign top_o   = mem_q[top_idx];

   // a push and a pop together overwrite the top, which also works when full
   assign do_pop  = pop_i && !empty_o;
   assign do_push = push_i && (!full_o || do_pop);

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         ptr_q <= '0;
      end else if (do_push && !do_pop) begin
         ptr_q <= ptr_q + PW'(1);
      end else if (do_pop && !do_push) begin
         ptr_q <= ptr_q - PW'(1);
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push && do_pop) begin
         mem_q[top_idx] <= push_addr_i;
      end else if (do_push) begin
         mem_q[IW'(ptr_q)] <= push_addr_i;
      end
   end

endmodule

// ==== logic/landing_pad_checker.sv ====
// forward edge check; the instruction committed right after a call must be a landing pad with a valid count
`timescale 1ns/10ps

module landing_pad_checker (
   input  logic                                                   clk_i,
   input  logic                                                   rst_ni,
   input  logic                                                   csr_en_i,
   input  cfi_pkg::commit_class_t [cfi_pkg::NR_COMMIT_PORTS-1:0]  cls_i,
   output cfi_pkg::violation_t                                    pad_viol_o,
   output logic                                                   args_clear_o
);

   typedef enum logic {
      IDLE,
      WAIT_PAD
   } state_e;

   state_e state_q, state_d;
   logic   checked;
   logic   args_clear_q;

   ////////////////////////////////////////////////////////////////////////////
   // next-state and check logic
   ////////////////////////////////////////////////////////////////////////////

   // ports are walked oldest first, a call arms the check for the next valid port
   always_comb begin
      logic pending;

      pending    = (state_q == WAIT_PAD);
      checked    = 1'b0;
      pad_viol_o = '0;

      for (int i = 0; i < cfi_pkg::NR_COMMIT_PORTS; i++) begin
         if (cls_i[i].valid) begin
            if (pending) begin
               checked = 1'b1;
               // only the first failing pad of the cycle is reported
               if (!cls_i[i].landing_ok && !pad_viol_o.valid) begin
                  pad_viol_o.valid = 1'b1;
                  pad_viol_o.tval  = cls_i[i].pc;
               end
            end
            pending = cls_i[i].is_call;
         end
      end

      state_d = pending ? WAIT_PAD : IDLE;
   end

   ////////////////////////////////////////////////////////////////////////////
   // registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q      <= IDLE;
         args_clear_q <= 1'b0;
      end else begin
         state_q      <= state_d;
         // the argument CSR is consumed by each check, and held clear while disabled
         args_clear_q <= checked || !csr_en_i;
      end
   end

   assign args_clear_o = args_clear_q;

endmodule

// ==== logic/commit_classifier.sv ====
// combinational decode of both commit ports; ports that are not acknowledged or carry an exception read as invalid
`timescale 1ns/10ps

module commit_classifier (
   input  logic                                                   clk_i,
   input  logic                                                   rst_ni,
   input  logic [cfi_pkg::NR_COMMIT_PORTS-1:0]                    commit_ack_i,
   input  cfi_pkg::commit_entry_t [cfi_pkg::NR_COMMIT_PORTS-1:0]  commit_instr_i,
   input  logic [cfi_pkg::NARGS_W-1:0]                            csr_nargs_i,
   output cfi_pkg::commit_class_t [cfi_pkg::NR_COMMIT_PORTS-1:0]  cls_o
);

   // clock and reset only keep the port list uniform with the checkers

   always_comb begin
      logic [cfi_pkg::NARGS_W-1:0] pad_nargs;
      logic                        variadic;
      logic                        args_ok;
      logic                        link_rd;
      logic                        link_rs1;
      logic                        pad_shape;

      for (int i = 0; i < cfi_pkg::NR_COMMIT_PORTS; i++) begin
         // the pad immediate holds the count in 10:2 and the variadic flag in 11
         pad_nargs = commit_instr_i[i].result[10:2];
         variadic  = commit_instr_i[i].result[11];

         if (csr_nargs_i == cfi_pkg::NARGS_UNSET) begin
            args_ok = 1'b1;
         end else if (variadic) begin
            args_ok = (pad_nargs >= csr_nargs_i);
         end else begin
            args_ok = (pad_nargs == csr_nargs_i);
         end

         link_rd  = (commit_instr_i[i].rd == cfi_pkg::REG_RA) ||
                    (commit_instr_i[i].rd == cfi_pkg::REG_T0);
         link_rs1 = (commit_instr_i[i].rs1 == cfi_pkg::REG_RA) ||
                    (commit_instr_i[i].rs1 == cfi_pkg::REG_T0);

         pad_shape = (commit_instr_i[i].op == cfi_pkg::OP_ADD) &&
                     (commit_instr_i[i].rd == 5'd0) &&
                     (commit_instr_i[i].rs1 == 5'd0) &&
                     (commit_instr_i[i].result[1:0] == cfi_pkg::LANDING_MARK);

         cls_o[i].valid      = commit_ack_i[i] && !commit_instr_i[i].ex_valid;
         cls_o[i].is_call    = link_rd &&
                               ((commit_instr_i[i].op == cfi_pkg::OP_JAL) ||
                                (commit_instr_i[i].op == cfi_pkg::OP_JALR));
         cls_o[i].is_ret     = (commit_instr_i[i].op == cfi_pkg::OP_JALR) &&
                               (commit_instr_i[i].rd == 5'd0) && link_rs1;
         cls_o[i].landing_ok = pad_shape && args_ok;
         cls_o[i].pc         = commit_instr_i[i].pc;
      end
   end

endmodule

// ==== logic/cfi_pkg.sv ====
// shared types and encodings for the CFI monitor; the checking order assumes exactly two ports
package cfi_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths and encodings
   ////////////////////////////////////////////////////////////////////////////

   localparam int unsigned XLEN            = 32;
   localparam int unsigned NR_COMMIT_PORTS = 2;
   localparam int unsigned NARGS_W         = 9;

   // link registers used by the calling convention
   localparam logic [4:0] REG_RA = 5'd1;
   localparam logic [4:0] REG_T0 = 5'd5;

   // a landing pad is addi x0, x0, imm with imm[1:0] set to this mark
   localparam logic [1:0] LANDING_MARK = 2'd2;

   // software writes all ones to the argument CSR when no count is set
   localparam logic [NARGS_W-1:0] NARGS_UNSET = '1;

   localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSTR = 32'd2;

   // offset from a call to its return address
   localparam logic [XLEN-1:0] RET_OFFSET = 32'd4;

   ////////////////////////////////////////////////////////////////////////////
   // commit stream and result types
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      OP_ADD,
      OP_JAL,
      OP_JALR,
      OP_OTHER
   } fu_op_e;

   // one committed instruction as seen on a commit port
   typedef struct packed {
      logic [XLEN-1:0] pc;
      fu_op_e          op;
      logic [4:0]      rd;
      logic [4:0]      rs1;
      logic [XLEN-1:0] result;   // immediate for landing pads
      logic            ex_valid;
   } commit_entry_t;

   typedef struct packed {
      logic            valid;
      logic            is_call;
      logic            is_ret;
      logic            landing_ok;
      logic [XLEN-1:0] pc;
   } commit_class_t;

   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] tval;
   } violation_t;

   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] cause;
      logic [XLEN-1:0] tval;
   } exception_t;

endpackage
